// File: Bender.yml
package:
  name: pipe_regs

sources:
  - files:
      - hw/pipe_pkg.sv
      - hw/fetch_decode_reg.sv
      - hw/decode_execute_reg.sv
      - hw/mem_access_align.sv
      - hw/execute_memory_reg.sv
      - hw/memory_writeback_reg.sv
      - hw/pipe_regs_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/pipe_regs_tb.sv

// File: hw/decode_execute_reg.sv
`timescale 1ns/10ps

module decode_execute_reg
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         load_i,
    input  logic         valid_i,
    input  word_t        pc_i,
    input  order_t       order_i,
    input  word_t        u_imm_i,
    input  exe_fwd_sel_t exe_fwd_sel_i,
    input  mar_sel_t     mar_sel_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    input  funct3_t      funct3_i,
    input  mem_fwd_sel_t mem_fwd_sel_i,
    input  logic         ld_reg_i,
    input  reg_idx_t     rd_i,
    output logic         valid_o,
    output word_t        pc_o,
    output order_t       order_o,
    output word_t        u_imm_o,
    output exe_fwd_sel_t exe_fwd_sel_o,
    output mar_sel_t     mar_sel_o,
    output logic         mem_read_o,
    output logic         mem_write_o,
    output funct3_t      funct3_o,
    output mem_fwd_sel_t mem_fwd_sel_o,
    output logic         ld_reg_o,
    output reg_idx_t     rd_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o       <= 1'b0;
            pc_o          <= RESET_PC; // boot vector
            order_o       <= '0;
            u_imm_o       <= '0;
            exe_fwd_sel_o <= EXE_FWD_ALU;
            mar_sel_o     <= MAR_PC;
            mem_read_o    <= 1'b0;
            mem_write_o   <= 1'b0;
            funct3_o      <= '0;
            mem_fwd_sel_o <= MEM_FWD_RDATA;
            ld_reg_o      <= 1'b0;
            rd_o          <= '0;
        end else if (load_i) begin
            valid_o       <= valid_i; // bubble from fd stays a bubble
            pc_o          <= pc_i;
            order_o       <= order_i;
            u_imm_o       <= u_imm_i;
            exe_fwd_sel_o <= exe_fwd_sel_i;
            mar_sel_o     <= mar_sel_i;
            mem_read_o    <= mem_read_i;
            mem_write_o   <= mem_write_i;
            funct3_o      <= funct3_i;
            mem_fwd_sel_o <= mem_fwd_sel_i;
            ld_reg_o      <= ld_reg_i;
            rd_o          <= rd_i;
        end
    end

endmodule

// File: hw/execute_memory_reg.sv
`timescale 1ns/10ps

module execute_memory_reg
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         load_i,
    input  logic         flush_i,
    input  logic         valid_i,
    input  word_t        alu_out_i,
    input  word_t        rs2_i,
    input  word_t        u_imm_i,
    input  word_t        pc_i,
    input  logic         br_en_i,
    input  order_t       order_i,
    input  exe_fwd_sel_t exe_fwd_sel_i,
    input  mar_sel_t     mar_sel_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    input  funct3_t      funct3_i,
    input  mem_fwd_sel_t mem_fwd_sel_i,
    input  logic         ld_reg_i,
    input  reg_idx_t     rd_i,
    output word_t        exe_fwd_data_o,
    output word_t        dmem_addr_o,
    output word_t        dmem_wdata_o,
    output mask_t        dmem_byte_en_o,
    output logic         mem_read_o,
    output logic         mem_write_o,
    output mem_fwd_sel_t mem_fwd_sel_o,
    output logic         ld_reg_o,
    output reg_idx_t     rd_o,
    output order_t       order_o,
    output logic         valid_o
);

    word_t exe_fwd;
    word_t raw_addr;
    word_t aligned_addr;
    mask_t byte_en;
    logic  mem_load;

    always_comb begin
        case (exe_fwd_sel_i)
            EXE_FWD_BR:   exe_fwd = {{(XLEN-1){1'b0}}, br_en_i};
            EXE_FWD_UIMM: exe_fwd = u_imm_i; // lui
            default:      exe_fwd = alu_out_i;
        endcase
    end

    assign raw_addr = (mar_sel_i == MAR_PC) ? pc_i : alu_out_i;

    mem_access_align u_align (
        .addr_i      (raw_addr),
        .mem_read_i  (mem_read_i),
        .mem_write_i (mem_write_i),
        .funct3_i    (funct3_i),
        .addr_o      (aligned_addr),
        .byte_en_o   (byte_en)
    );

    // prime the dcache request so mem stage can start at once
    assign mem_load = load_i && (mem_read_i || mem_write_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dmem_addr_o    <= '0;
            dmem_wdata_o   <= '0;
            dmem_byte_en_o <= '0;
        end else if (mem_load) begin
            dmem_addr_o    <= aligned_addr;
            dmem_wdata_o   <= rs2_i;
            dmem_byte_en_o <= byte_en;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe_fwd_data_o <= '0;
            mem_read_o     <= 1'b0;
            mem_write_o    <= 1'b0;
            mem_fwd_sel_o  <= MEM_FWD_RDATA;
            ld_reg_o       <= 1'b0;
            rd_o           <= '0;
            order_o        <= '0;
        end else if (load_i) begin
            exe_fwd_data_o <= exe_fwd;
            mem_read_o     <= mem_read_i;
            mem_write_o    <= mem_write_i;
            mem_fwd_sel_o  <= mem_fwd_sel_i;
            ld_reg_o       <= ld_reg_i;
            rd_o           <= rd_i;
            order_o        <= order_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0; // flush beats load
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

endmodule

// File: hw/fetch_decode_reg.sv
`timescale 1ns/10ps

module fetch_decode_reg
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   load_i,
    input  logic   flush_i,
    input  word_t  instr_i,
    input  word_t  pc_i,
    output word_t  instr_o,
    output word_t  pc_o,
    output order_t order_o,
    output logic   valid_o
);

    order_t order_cnt; // next order to hand out

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_o <= '0;
            pc_o    <= '0;
            valid_o <= 1'b0;
        end else if (flush_i) begin
            instr_o <= '0; // bubble into decode
            pc_o    <= '0;
            valid_o <= 1'b0;
        end else if (load_i) begin
            instr_o <= instr_i;
            pc_o    <= pc_i;
            valid_o <= 1'b1;
        end
    end

    // commit order numbering, flushed slots do not consume a number
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            order_cnt <= '0;
            order_o   <= '0;
        end else if (load_i && !flush_i) begin
            order_o   <= order_cnt; // value before increment
            order_cnt <= order_cnt + order_t'(1);
        end
    end

endmodule

// File: hw/mem_access_align.sv
`timescale 1ns/10ps

module mem_access_align
    import pipe_pkg::*;
(
    input  word_t   addr_i,
    input  logic    mem_read_i,
    input  logic    mem_write_i,
    input  funct3_t funct3_i,
    output word_t   addr_o,
    output mask_t   byte_en_o
);

    logic [1:0] byte_off;
    word_t      word_addr;
    mask_t      half_mask;
    mask_t      byte_mask;

    assign byte_off  = addr_i[1:0];
    assign word_addr = {addr_i[XLEN-1:2], 2'b00};
    assign half_mask = mask_t'(4'b0011 << byte_off); // lanes of the half
    assign byte_mask = mask_t'(4'b0001 << byte_off);

    always_comb begin
        byte_en_o = '0;
        addr_o    = addr_i;
        if (mem_read_i) begin // read wins if both are set
            case (funct3_i)
                F3_LW: byte_en_o = '1;
                F3_LH, F3_LHU: begin
                    byte_en_o = half_mask;
                    addr_o    = word_addr;
                end
                F3_LB, F3_LBU: begin
                    byte_en_o = byte_mask;
                    addr_o    = word_addr;
                end
                default: byte_en_o = '0;
            endcase
        end else if (mem_write_i) begin
            case (funct3_i)
                F3_SW: byte_en_o = '1;
                F3_SH: begin
                    byte_en_o = half_mask;
                    addr_o    = word_addr;
                end
                F3_SB: begin
                    byte_en_o = byte_mask;
                    addr_o    = word_addr;
                end
                default: byte_en_o = '0;
            endcase
        end
    end

endmodule

// File: hw/memory_writeback_reg.sv
`timescale 1ns/10ps

module memory_writeback_reg
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         load_i,
    input  logic         wb_fwd_load_i,
    input  logic         valid_i,
    input  word_t        exe_fwd_data_i,
    input  word_t        mem_rdata_i,
    input  mem_fwd_sel_t mem_fwd_sel_i,
    input  logic         ld_reg_i,
    input  reg_idx_t     rd_i,
    input  order_t       order_i,
    output word_t        mem_fwd_data_o,
    output word_t        wb_fwd_data_o,
    output logic         ld_reg_o,
    output reg_idx_t     rd_o,
    output order_t       order_o,
    output logic         valid_o
);

    word_t mem_fwd;

    always_comb begin
        case (mem_fwd_sel_i)
            MEM_FWD_EXE: mem_fwd = exe_fwd_data_i;
            default:     mem_fwd = mem_rdata_i; // load result
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_fwd_data_o <= '0;
            ld_reg_o       <= 1'b0;
            rd_o           <= '0;
            order_o        <= '0;
            valid_o        <= 1'b0;
        end else if (load_i) begin
            mem_fwd_data_o <= mem_fwd;
            ld_reg_o       <= ld_reg_i;
            rd_o           <= rd_i;
            order_o        <= order_i;
            valid_o        <= valid_i;
        end
    end

    // older copy for forwarding one instruction further back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_fwd_data_o <= '0;
        end else if (wb_fwd_load_i) begin
            wb_fwd_data_o <= mem_fwd_data_o;
        end
    end

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

    localparam int XLEN      = 32;
    localparam int ORDER_W   = 64;
    localparam int MASK_W    = 4;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ORDER_W-1:0]   order_t;
    typedef logic [MASK_W-1:0]    mask_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;

    // load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store widths
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    typedef logic [1:0] exe_fwd_sel_t;
    localparam exe_fwd_sel_t EXE_FWD_ALU  = 2'd0;
    localparam exe_fwd_sel_t EXE_FWD_BR   = 2'd1;
    localparam exe_fwd_sel_t EXE_FWD_UIMM = 2'd2; // code 3 falls back to alu

    typedef logic mar_sel_t;
    localparam mar_sel_t MAR_PC  = 1'b0;
    localparam mar_sel_t MAR_ALU = 1'b1;

    typedef logic mem_fwd_sel_t;
    localparam mem_fwd_sel_t MEM_FWD_RDATA = 1'b0;
    localparam mem_fwd_sel_t MEM_FWD_EXE   = 1'b1;

    localparam word_t RESET_PC = 32'h40000000;

endpackage

// File: hw/pipe_regs_top.sv
`timescale 1ns/10ps

module pipe_regs_top
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         fd_load_i,
    input  logic         de_load_i,
    input  logic         em_load_i,
    input  logic         mw_load_i,
    input  logic         wb_fwd_load_i,
    input  logic         fd_flush_i,
    input  logic         em_flush_i,
    input  word_t        instr_i,
    input  word_t        pc_i,
    input  word_t        u_imm_i,
    input  exe_fwd_sel_t exe_fwd_sel_i,
    input  mar_sel_t     mar_sel_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    input  funct3_t      funct3_i,
    input  mem_fwd_sel_t mem_fwd_sel_i,
    input  logic         ld_reg_i,
    input  reg_idx_t     rd_i,
    input  word_t        alu_out_i,
    input  word_t        rs2_i,
    input  logic         br_en_i,
    input  word_t        mem_rdata_i,
    output word_t        dec_instr_o,
    output word_t        dec_pc_o,
    output order_t       dec_order_o,
    output logic         dec_valid_o,
    output word_t        exe_u_imm_o,
    output word_t        exe_pc_o,
    output logic         exe_valid_o,
    output word_t        exe_fwd_data_o,
    output word_t        dmem_addr_o,
    output word_t        dmem_wdata_o,
    output mask_t        dmem_byte_en_o,
    output logic         dmem_read_o,
    output logic         dmem_write_o,
    output logic         em_valid_o,
    output word_t        mem_fwd_data_o,
    output word_t        wb_fwd_data_o,
    output logic         wb_ld_reg_o,
    output reg_idx_t     wb_rd_o,
    output order_t       wb_order_o,
    output logic         wb_valid_o
);

    // decode/execute to execute/memory
    order_t       de_order;
    exe_fwd_sel_t de_exe_fwd_sel;
    mar_sel_t     de_mar_sel;
    logic         de_mem_read;
    logic         de_mem_write;
    funct3_t      de_funct3;
    mem_fwd_sel_t de_mem_fwd_sel;
    logic         de_ld_reg;
    reg_idx_t     de_rd;

    // execute/memory to memory/writeback
    mem_fwd_sel_t em_mem_fwd_sel;
    logic         em_ld_reg;
    reg_idx_t     em_rd;
    order_t       em_order;

    fetch_decode_reg u_fd (
        .clk     (clk),
        .rst     (rst),
        .load_i  (fd_load_i),
        .flush_i (fd_flush_i),
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .instr_o (dec_instr_o),
        .pc_o    (dec_pc_o),
        .order_o (dec_order_o),
        .valid_o (dec_valid_o)
    );

    decode_execute_reg u_de (
        .clk           (clk),
        .rst           (rst),
        .load_i        (de_load_i),
        .valid_i       (dec_valid_o),
        .pc_i          (dec_pc_o),
        .order_i       (dec_order_o),
        .u_imm_i       (u_imm_i),
        .exe_fwd_sel_i (exe_fwd_sel_i),
        .mar_sel_i     (mar_sel_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .funct3_i      (funct3_i),
        .mem_fwd_sel_i (mem_fwd_sel_i),
        .ld_reg_i      (ld_reg_i),
        .rd_i          (rd_i),
        .valid_o       (exe_valid_o),
        .pc_o          (exe_pc_o),
        .order_o       (de_order),
        .u_imm_o       (exe_u_imm_o),
        .exe_fwd_sel_o (de_exe_fwd_sel),
        .mar_sel_o     (de_mar_sel),
        .mem_read_o    (de_mem_read),
        .mem_write_o   (de_mem_write),
        .funct3_o      (de_funct3),
        .mem_fwd_sel_o (de_mem_fwd_sel),
        .ld_reg_o      (de_ld_reg),
        .rd_o          (de_rd)
    );

    execute_memory_reg u_em (
        .clk            (clk),
        .rst            (rst),
        .load_i         (em_load_i),
        .flush_i        (em_flush_i),
        .valid_i        (exe_valid_o),
        .alu_out_i      (alu_out_i),
        .rs2_i          (rs2_i),
        .u_imm_i        (exe_u_imm_o),
        .pc_i           (exe_pc_o),
        .br_en_i        (br_en_i),
        .order_i        (de_order),
        .exe_fwd_sel_i  (de_exe_fwd_sel),
        .mar_sel_i      (de_mar_sel),
        .mem_read_i     (de_mem_read),
        .mem_write_i    (de_mem_write),
        .funct3_i       (de_funct3),
        .mem_fwd_sel_i  (de_mem_fwd_sel),
        .ld_reg_i       (de_ld_reg),
        .rd_i           (de_rd),
        .exe_fwd_data_o (exe_fwd_data_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_byte_en_o (dmem_byte_en_o),
        .mem_read_o     (dmem_read_o),
        .mem_write_o    (dmem_write_o),
        .mem_fwd_sel_o  (em_mem_fwd_sel),
        .ld_reg_o       (em_ld_reg),
        .rd_o           (em_rd),
        .order_o        (em_order),
        .valid_o        (em_valid_o)
    );

    memory_writeback_reg u_mw (
        .clk            (clk),
        .rst            (rst),
        .load_i         (mw_load_i),
        .wb_fwd_load_i  (wb_fwd_load_i),
        .valid_i        (em_valid_o),
        .exe_fwd_data_i (exe_fwd_data_o),
        .mem_rdata_i    (mem_rdata_i),
        .mem_fwd_sel_i  (em_mem_fwd_sel),
        .ld_reg_i       (em_ld_reg),
        .rd_i           (em_rd),
        .order_i        (em_order),
        .mem_fwd_data_o (mem_fwd_data_o),
        .wb_fwd_data_o  (wb_fwd_data_o),
        .ld_reg_o       (wb_ld_reg_o),
        .rd_o           (wb_rd_o),
        .order_o        (wb_order_o),
        .valid_o        (wb_valid_o)
    );

endmodule

// File: sim.f
hw/pipe_pkg.sv
hw/fetch_decode_reg.sv
hw/decode_execute_reg.sv
hw/mem_access_align.sv
hw/execute_memory_reg.sv
hw/memory_writeback_reg.sv
hw/pipe_regs_top.sv
sim/tb_clk_gen.sv
sim/pipe_regs_tb.sv

// File: sim/pipe_regs_tb.sv
`timescale 1ns/10ps

module pipe_regs_tb
    import pipe_pkg::*;
();

    localparam int CLK_PERIOD_NS    = 10;
    localparam int RESET_CYCLES     = 2;
    localparam int FULL_FLOW_CYCLES = 200;
    localparam int RANDOM_CYCLES    = 400;
    localparam int DRAIN_CYCLES     = 8;
    localparam int TEST_CYCLES      = RESET_CYCLES + FULL_FLOW_CYCLES + RANDOM_CYCLES
                                      + DRAIN_CYCLES + 2;
    localparam int MARGIN_NS        = 200;
    localparam int WATCHDOG_NS      = TEST_CYCLES * CLK_PERIOD_NS + MARGIN_NS;

    logic         clk;
    logic         rst;
    logic         fd_load, de_load, em_load, mw_load, wb_fwd_load;
    logic         fd_flush, em_flush;
    word_t        instr, pc, u_imm, alu_out, rs2, mem_rdata;
    exe_fwd_sel_t exe_fwd_sel;
    mar_sel_t     mar_sel;
    logic         mem_read, mem_write, ld_reg, br_en;
    funct3_t      funct3;
    mem_fwd_sel_t mem_fwd_sel;
    reg_idx_t     rd;
    integer       seed = 32'h5f81;
    funct3_t      f3_codes [0:7] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU, F3_SB, F3_SH, F3_SW};

    // reference model of the stage registers
    word_t        m_fd_instr, m_fd_pc;
    order_t       m_fd_order, m_next_order;
    logic         m_fd_valid;
    word_t        m_de_pc, m_de_u_imm;
    order_t       m_de_order;
    logic         m_de_valid, m_de_mem_read, m_de_mem_write, m_de_ld_reg;
    exe_fwd_sel_t m_de_exe_sel;
    mar_sel_t     m_de_mar_sel;
    funct3_t      m_de_funct3;
    mem_fwd_sel_t m_de_mfs;
    reg_idx_t     m_de_rd;
    word_t        m_em_fwd, m_em_addr, m_em_wdata;
    mask_t        m_em_be;
    logic         m_em_mem_read, m_em_mem_write, m_em_ld_reg, m_em_valid;
    mem_fwd_sel_t m_em_mfs;
    reg_idx_t     m_em_rd;
    order_t       m_em_order;
    word_t        m_mw_fwd, m_wb_fwd;
    logic         m_mw_ld_reg, m_mw_valid;
    reg_idx_t     m_mw_rd;
    order_t       m_mw_order;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    pipe_regs_top u_dut (
        .clk (clk), .rst (rst),
        .fd_load_i (fd_load), .de_load_i (de_load), .em_load_i (em_load),
        .mw_load_i (mw_load), .wb_fwd_load_i (wb_fwd_load),
        .fd_flush_i (fd_flush), .em_flush_i (em_flush),
        .instr_i (instr), .pc_i (pc), .u_imm_i (u_imm),
        .exe_fwd_sel_i (exe_fwd_sel), .mar_sel_i (mar_sel),
        .mem_read_i (mem_read), .mem_write_i (mem_write), .funct3_i (funct3),
        .mem_fwd_sel_i (mem_fwd_sel), .ld_reg_i (ld_reg), .rd_i (rd),
        .alu_out_i (alu_out), .rs2_i (rs2), .br_en_i (br_en), .mem_rdata_i (mem_rdata),
        .dec_instr_o (), .dec_pc_o (), .dec_order_o (), .dec_valid_o (),
        .exe_u_imm_o (), .exe_pc_o (), .exe_valid_o (), .exe_fwd_data_o (),
        .dmem_addr_o (), .dmem_wdata_o (), .dmem_byte_en_o (),
        .dmem_read_o (), .dmem_write_o (), .em_valid_o (),
        .mem_fwd_data_o (), .wb_fwd_data_o (), .wb_ld_reg_o (), .wb_rd_o (),
        .wb_order_o (), .wb_valid_o ()
    );

    task abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task report_mismatch(input string name, input logic [63:0] got, input logic [63:0] expected);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
        abort_run();
    endtask

    // bytes touched by the access
    function automatic int access_size(input logic rd_en, input logic wr_en, input funct3_t f3);
        if (rd_en) begin
            if (f3 == F3_LW) return 4;
            if (f3 == F3_LH || f3 == F3_LHU) return 2;
            if (f3 == F3_LB || f3 == F3_LBU) return 1;
            return 0;
        end
        if (wr_en) begin
            if (f3 == F3_SW) return 4;
            if (f3 == F3_SH) return 2;
            if (f3 == F3_SB) return 1;
        end
        return 0;
    endfunction

    function automatic mask_t lane_mask(input int size, input word_t addr);
        case (size)
            4: return 4'hf;
            2: return mask_t'(4'h3 << addr[1:0]);
            1: return mask_t'(4'h1 << addr[1:0]);
            default: return 4'h0;
        endcase
    endfunction

    function automatic word_t access_addr(input int size, input word_t addr);
        if (size == 1 || size == 2) return addr & ~word_t'(3); // sub-word goes to word base
        return addr;
    endfunction

    always @(posedge clk or posedge rst) begin
        int    size;
        word_t raw;
        if (rst) begin
            m_fd_instr     <= '0;
            m_fd_pc        <= '0;
            m_fd_order     <= '0;
            m_next_order   <= '0;
            m_fd_valid     <= 1'b0;
            m_de_pc        <= RESET_PC;
            m_de_u_imm     <= '0;
            m_de_order     <= '0;
            m_de_valid     <= 1'b0;
            m_de_mem_read  <= 1'b0;
            m_de_mem_write <= 1'b0;
            m_de_ld_reg    <= 1'b0;
            m_de_exe_sel   <= '0;
            m_de_mar_sel   <= '0;
            m_de_funct3    <= '0;
            m_de_mfs       <= '0;
            m_de_rd        <= '0;
            m_em_fwd       <= '0;
            m_em_addr      <= '0;
            m_em_wdata     <= '0;
            m_em_be        <= '0;
            m_em_mem_read  <= 1'b0;
            m_em_mem_write <= 1'b0;
            m_em_ld_reg    <= 1'b0;
            m_em_valid     <= 1'b0;
            m_em_mfs       <= '0;
            m_em_rd        <= '0;
            m_em_order     <= '0;
            m_mw_fwd       <= '0;
            m_wb_fwd       <= '0;
            m_mw_ld_reg    <= 1'b0;
            m_mw_valid     <= 1'b0;
            m_mw_rd        <= '0;
            m_mw_order     <= '0;
        end else begin
            if (fd_flush) begin
                m_fd_instr <= '0;
                m_fd_pc    <= '0;
                m_fd_valid <= 1'b0;
            end else if (fd_load) begin
                m_fd_instr   <= instr;
                m_fd_pc      <= pc;
                m_fd_valid   <= 1'b1;
                m_fd_order   <= m_next_order;
                m_next_order <= m_next_order + 1;
            end
            if (de_load) begin
                m_de_pc        <= m_fd_pc;
                m_de_order     <= m_fd_order;
                m_de_valid     <= m_fd_valid;
                m_de_u_imm     <= u_imm;
                m_de_exe_sel   <= exe_fwd_sel;
                m_de_mar_sel   <= mar_sel;
                m_de_mem_read  <= mem_read;
                m_de_mem_write <= mem_write;
                m_de_funct3    <= funct3;
                m_de_mfs       <= mem_fwd_sel;
                m_de_ld_reg    <= ld_reg;
                m_de_rd        <= rd;
            end
            if (em_load) begin
                if (m_de_exe_sel == EXE_FWD_BR) m_em_fwd <= word_t'(br_en);
                else if (m_de_exe_sel == EXE_FWD_UIMM) m_em_fwd <= m_de_u_imm;
                else m_em_fwd <= alu_out;
                m_em_mem_read  <= m_de_mem_read;
                m_em_mem_write <= m_de_mem_write;
                m_em_mfs       <= m_de_mfs;
                m_em_ld_reg    <= m_de_ld_reg;
                m_em_rd        <= m_de_rd;
                m_em_order     <= m_de_order;
                if (m_de_mem_read || m_de_mem_write) begin
                    raw  = (m_de_mar_sel == MAR_PC) ? m_de_pc : alu_out;
                    size = access_size(m_de_mem_read, m_de_mem_write, m_de_funct3);
                    m_em_addr  <= access_addr(size, raw);
                    m_em_be    <= lane_mask(size, raw);
                    m_em_wdata <= rs2;
                end
            end
            if (em_flush) m_em_valid <= 1'b0; // flush beats load
            else if (em_load) m_em_valid <= m_de_valid;
            if (mw_load) begin
                m_mw_fwd    <= (m_em_mfs == MEM_FWD_EXE) ? m_em_fwd : mem_rdata;
                m_mw_ld_reg <= m_em_ld_reg;
                m_mw_rd     <= m_em_rd;
                m_mw_order  <= m_em_order;
                m_mw_valid  <= m_em_valid;
            end
            if (wb_fwd_load) m_wb_fwd <= m_mw_fwd;
        end
    end

    property holds_value(got, expected);
        @(posedge clk) disable iff (rst) got === expected;
    endproperty

    a_dec_instr: assert property (holds_value(u_dut.dec_instr_o, m_fd_instr))
        else report_mismatch("dec_instr_o", $sampled(u_dut.dec_instr_o), $sampled(m_fd_instr));
    a_dec_pc: assert property (holds_value(u_dut.dec_pc_o, m_fd_pc))
        else report_mismatch("dec_pc_o", $sampled(u_dut.dec_pc_o), $sampled(m_fd_pc));
    a_dec_order: assert property (holds_value(u_dut.dec_order_o, m_fd_order))
        else report_mismatch("dec_order_o", $sampled(u_dut.dec_order_o), $sampled(m_fd_order));
    a_dec_valid: assert property (holds_value(u_dut.dec_valid_o, m_fd_valid))
        else report_mismatch("dec_valid_o", $sampled(u_dut.dec_valid_o), $sampled(m_fd_valid));
    a_exe_u_imm: assert property (holds_value(u_dut.exe_u_imm_o, m_de_u_imm))
        else report_mismatch("exe_u_imm_o", $sampled(u_dut.exe_u_imm_o), $sampled(m_de_u_imm));
    a_exe_pc: assert property (holds_value(u_dut.exe_pc_o, m_de_pc))
        else report_mismatch("exe_pc_o", $sampled(u_dut.exe_pc_o), $sampled(m_de_pc));
    a_exe_valid: assert property (holds_value(u_dut.exe_valid_o, m_de_valid))
        else report_mismatch("exe_valid_o", $sampled(u_dut.exe_valid_o), $sampled(m_de_valid));
    a_exe_fwd: assert property (holds_value(u_dut.exe_fwd_data_o, m_em_fwd))
        else report_mismatch("exe_fwd_data_o", $sampled(u_dut.exe_fwd_data_o),
                             $sampled(m_em_fwd));
    a_dmem_addr: assert property (holds_value(u_dut.dmem_addr_o, m_em_addr))
        else report_mismatch("dmem_addr_o", $sampled(u_dut.dmem_addr_o), $sampled(m_em_addr));
    a_dmem_wdata: assert property (holds_value(u_dut.dmem_wdata_o, m_em_wdata))
        else report_mismatch("dmem_wdata_o", $sampled(u_dut.dmem_wdata_o),
                             $sampled(m_em_wdata));
    a_dmem_be: assert property (holds_value(u_dut.dmem_byte_en_o, m_em_be))
        else report_mismatch("dmem_byte_en_o", $sampled(u_dut.dmem_byte_en_o),
                             $sampled(m_em_be));
    a_dmem_read: assert property (holds_value(u_dut.dmem_read_o, m_em_mem_read))
        else report_mismatch("dmem_read_o", $sampled(u_dut.dmem_read_o),
                             $sampled(m_em_mem_read));
    a_dmem_write: assert property (holds_value(u_dut.dmem_write_o, m_em_mem_write))
        else report_mismatch("dmem_write_o", $sampled(u_dut.dmem_write_o),
                             $sampled(m_em_mem_write));
    a_em_valid: assert property (holds_value(u_dut.em_valid_o, m_em_valid))
        else report_mismatch("em_valid_o", $sampled(u_dut.em_valid_o), $sampled(m_em_valid));
    a_mem_fwd: assert property (holds_value(u_dut.mem_fwd_data_o, m_mw_fwd))
        else report_mismatch("mem_fwd_data_o", $sampled(u_dut.mem_fwd_data_o),
                             $sampled(m_mw_fwd));
    a_wb_fwd: assert property (holds_value(u_dut.wb_fwd_data_o, m_wb_fwd))
        else report_mismatch("wb_fwd_data_o", $sampled(u_dut.wb_fwd_data_o),
                             $sampled(m_wb_fwd));
    a_wb_ld_reg: assert property (holds_value(u_dut.wb_ld_reg_o, m_mw_ld_reg))
        else report_mismatch("wb_ld_reg_o", $sampled(u_dut.wb_ld_reg_o), $sampled(m_mw_ld_reg));
    a_wb_rd: assert property (holds_value(u_dut.wb_rd_o, m_mw_rd))
        else report_mismatch("wb_rd_o", $sampled(u_dut.wb_rd_o), $sampled(m_mw_rd));
    a_wb_order: assert property (holds_value(u_dut.wb_order_o, m_mw_order))
        else report_mismatch("wb_order_o", $sampled(u_dut.wb_order_o), $sampled(m_mw_order));
    a_wb_valid: assert property (holds_value(u_dut.wb_valid_o, m_mw_valid))
        else report_mismatch("wb_valid_o", $sampled(u_dut.wb_valid_o), $sampled(m_mw_valid));

    task check_reset_state();
        assert (u_dut.dec_valid_o === 1'b0)
            else report_mismatch("dec_valid_o", u_dut.dec_valid_o, 0);
        assert (u_dut.exe_valid_o === 1'b0)
            else report_mismatch("exe_valid_o", u_dut.exe_valid_o, 0);
        assert (u_dut.em_valid_o === 1'b0)
            else report_mismatch("em_valid_o", u_dut.em_valid_o, 0);
        assert (u_dut.wb_valid_o === 1'b0)
            else report_mismatch("wb_valid_o", u_dut.wb_valid_o, 0);
        assert (u_dut.dmem_byte_en_o === '0)
            else report_mismatch("dmem_byte_en_o", u_dut.dmem_byte_en_o, 0);
        assert (u_dut.dec_order_o === '0)
            else report_mismatch("dec_order_o", u_dut.dec_order_o, 0);
        assert (u_dut.wb_order_o === '0)
            else report_mismatch("wb_order_o", u_dut.wb_order_o, 0);
        assert (u_dut.exe_pc_o === RESET_PC)
            else report_mismatch("exe_pc_o", u_dut.exe_pc_o, RESET_PC);
    endtask

    task drive_loads(input logic all_high);
        if (all_high) begin
            fd_load     <= 1'b1;
            de_load     <= 1'b1;
            em_load     <= 1'b1;
            mw_load     <= 1'b1;
            wb_fwd_load <= 1'b1;
            fd_flush    <= 1'b0;
            em_flush    <= 1'b0;
        end else begin
            fd_load     <= ($random(seed) & 3) != 0; // stalls about one cycle in four
            de_load     <= ($random(seed) & 3) != 0;
            em_load     <= ($random(seed) & 3) != 0;
            mw_load     <= ($random(seed) & 3) != 0;
            wb_fwd_load <= ($random(seed) & 1) != 0;
            fd_flush    <= ($random(seed) & 7) == 0;
            em_flush    <= ($random(seed) & 7) == 0;
        end
    endtask

    task drive_operands();
        integer pick;
        pick = $random(seed);
        instr       <= $random(seed);
        pc          <= $random(seed);
        u_imm       <= $random(seed) & 32'hfffff000;
        exe_fwd_sel <= exe_fwd_sel_t'($random(seed));
        mar_sel     <= mar_sel_t'($random(seed));
        mem_read    <= ($random(seed) & 1) != 0;
        mem_write   <= ($random(seed) & 1) != 0;
        mem_fwd_sel <= mem_fwd_sel_t'($random(seed));
        ld_reg      <= ($random(seed) & 1) != 0;
        rd          <= reg_idx_t'($random(seed));
        alu_out     <= $random(seed);
        rs2         <= $random(seed);
        br_en       <= ($random(seed) & 1) != 0;
        mem_rdata   <= $random(seed);
        if ((pick & 7) == 0) funct3 <= funct3_t'(pick >> 3); // unknown codes too
        else funct3 <= f3_codes[(pick >> 3) & 7];
    endtask

    initial begin
        fd_load     = 1'b0;
        de_load     = 1'b0;
        em_load     = 1'b0;
        mw_load     = 1'b0;
        wb_fwd_load = 1'b0;
        fd_flush    = 1'b0;
        em_flush    = 1'b0;
        instr       = '0;
        pc          = '0;
        u_imm       = '0;
        alu_out     = '0;
        rs2         = '0;
        mem_rdata   = '0;
        exe_fwd_sel = EXE_FWD_ALU;
        mar_sel     = MAR_PC;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        funct3      = '0;
        mem_fwd_sel = MEM_FWD_RDATA;
        ld_reg      = 1'b0;
        rd          = '0;
        br_en       = 1'b0;
        wait (rst === 1'b0);
        @(negedge clk);
        check_reset_state();
        repeat (FULL_FLOW_CYCLES) begin
            @(posedge clk);
            drive_loads(1'b1);
            drive_operands();
        end
        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            drive_loads(1'b0);
            drive_operands();
        end
        @(posedge clk);
        drive_loads(1'b1); // let the pipe drain
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);
        $display("sim passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD_NS = 5; // 10 ns clock
    localparam int RESET_CYCLES   = 2;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

    always #HALF_PERIOD_NS clk_o = ~clk_o;

endmodule
